/* sources.f */
+incdir+.
imuldiv_pkg.sv
int_mul_dpath.sv
int_mul_ctrl.sv
int_div_dpath.sv
int_div_ctrl.sv
int_muldiv_unit.sv
tb_int_muldiv.sv

/* Makefile */
# Verilator build and run for the multiply/divide unit testbench
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_int_muldiv
RTL_TOP   ?= int_muldiv_unit
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Regression passed

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# result is decided by the log, not by the exit code of the model
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_int_muldiv.sv */
/* directed testbench for int_muldiv_unit, checks every result against a reference model
   corner operands, back-pressure and LFSR random traffic, stops at the first error */

`include "imuldiv_defs.svh"

module tb_int_muldiv;
  timeunit 1ns;
  timeprecision 100ps;

  import imuldiv_pkg::*;

  // cycles any single wait may take before the run is abandoned
  localparam int wait_limit = 200;
  // galois feedback taps, right-shifting form
  localparam logic [31:0] lfsr_taps = 32'hD000_0001;

  logic       clk;
  logic       reset;
  muldiv_fn_t req_fn;
  word_t      req_a;
  word_t      req_b;
  logic       req_val;
  logic       req_rdy;
  dword_t     resp_result;
  logic       resp_val;
  logic       resp_rdy;

  logic [31:0] lfsr_q;

  int_muldiv_unit u_int_muldiv_unit (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // --------------------------------------------------------------------------
  // random source
  // --------------------------------------------------------------------------

  // one shift of the register per bit handed out
  function automatic logic next_lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ lfsr_taps;
    end
    return out;
  endfunction

  // n fresh bits, right aligned
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[`IMULDIV_XLEN-2:0], next_lfsr_bit()};
    end
    return v;
  endfunction

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  // products by plain 64-bit multiply, division by magnitude and sign
  function automatic dword_t ref_result(input muldiv_fn_t fn, input word_t a, input word_t b);
    logic signed [2*`IMULDIV_XLEN-1:0] sa;
    logic signed [2*`IMULDIV_XLEN-1:0] sb;
    logic   a_neg;
    logic   b_neg;
    word_t  a_mag;
    word_t  b_mag;
    word_t  q_mag;
    word_t  r_mag;
    word_t  q_val;
    word_t  r_val;
    dword_t res;
    case (fn)
      FN_MUL: begin
        sa  = {{`IMULDIV_XLEN{a[`IMULDIV_XLEN-1]}}, a};
        sb  = {{`IMULDIV_XLEN{b[`IMULDIV_XLEN-1]}}, b};
        res = dword_t'(sa * sb);
      end
      FN_MULU: begin
        res = {{`IMULDIV_XLEN{1'b0}}, a} * {{`IMULDIV_XLEN{1'b0}}, b};
      end
      default: begin
        a_neg = (fn == FN_DIV) && a[`IMULDIV_XLEN-1];
        b_neg = (fn == FN_DIV) && b[`IMULDIV_XLEN-1];
        a_mag = a_neg ? -a : a;
        b_mag = b_neg ? -b : b;
        // zero divisor: all-ones quotient, dividend kept as remainder
        if (b_mag == '0) begin
          q_mag = '1;
          r_mag = a_mag;
        end else begin
          q_mag = a_mag / b_mag;
          r_mag = a_mag % b_mag;
        end
        q_val = (a_neg ^ b_neg) ? -q_mag : q_mag;
        // remainder takes the dividend sign
        r_val = a_neg ? -r_mag : r_mag;
        res   = {r_val, q_val};
      end
    endcase
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // checking
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input dword_t got, input dword_t expected);
    if (got !== expected) begin
      $display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, expected);
      $display("Regression failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("timeout at %0t ns: %s never came within %0d cycles", $time, what, wait_limit);
    $display("Regression failed");
    $fatal(1, "wait timed out");
  endtask

  // one full request/response, response held back for stall cycles
  task automatic send_op(input muldiv_fn_t fn, input word_t a, input word_t b,
                         input dword_t expected, input int stall);
    int     waited;
    dword_t held;
    waited = 0;
    while (!req_rdy) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > wait_limit) begin
        timeout_abort("req_rdy");
      end
    end
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    @(posedge clk);
    #2;
    req_val = 1'b0;
    // accepted, so the unit is now busy
    check_value("req_rdy", dword_t'(req_rdy), 64'd0);
    waited = 0;
    while (!resp_val) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > wait_limit) begin
        timeout_abort("resp_val");
      end
    end
    check_value("resp_result", resp_result, expected);
    held = resp_result;
    // consumer stalls, response must sit still
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #2;
      check_value("resp_val", dword_t'(resp_val), 64'd1);
      check_value("resp_result", resp_result, held);
      check_value("req_rdy", dword_t'(req_rdy), 64'd0);
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    #2;
    resp_rdy = 1'b0;
    check_value("resp_val", dword_t'(resp_val), 64'd0);
    check_value("req_rdy", dword_t'(req_rdy), 64'd1);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    check_value("req_rdy", dword_t'(req_rdy), 64'd1);
    check_value("resp_val", dword_t'(resp_val), 64'd0);
  endtask

  task automatic test_corners(input muldiv_fn_t fn);
    word_t corner [6];
    corner[0] = 32'h0000_0000;
    corner[1] = 32'h0000_0001;
    corner[2] = 32'hFFFF_FFFF;
    corner[3] = 32'h8000_0000;
    corner[4] = 32'h7FFF_FFFF;
    corner[5] = 32'hFFFF_FFFD;
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 6; j++) begin
        send_op(fn, corner[i], corner[j], ref_result(fn, corner[i], corner[j]), 0);
      end
    end
  endtask

  // hand-worked results
  task automatic test_known_values();
    send_op(FN_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0000_0000_0000_0001, 0);
    send_op(FN_MULU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFE_0000_0001, 0);
    send_op(FN_MUL, 32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000, 0);
    send_op(FN_MUL, 32'h0000_0005, 32'hFFFF_FFFD, 64'hFFFF_FFFF_FFFF_FFF1, 0);
    // most negative over -1 wraps back onto itself
    send_op(FN_DIV, 32'h8000_0000, 32'hFFFF_FFFF, {32'h0000_0000, 32'h8000_0000}, 0);
    send_op(FN_DIV, 32'hFFFF_FFF9, 32'h0000_0002, {32'hFFFF_FFFF, 32'hFFFF_FFFD}, 0);
    send_op(FN_DIVU, 32'h0000_0064, 32'h0000_0000, {32'h0000_0064, 32'hFFFF_FFFF}, 0);
    // zero divisor, signs still applied
    send_op(FN_DIV, 32'hFFFF_FFFB, 32'h0000_0000, {32'hFFFF_FFFB, 32'h0000_0001}, 0);
  endtask

  task automatic test_backpressure();
    send_op(FN_MUL, 32'h1234_5678, 32'hFEDC_BA98,
            ref_result(FN_MUL, 32'h1234_5678, 32'hFEDC_BA98), 1);
    send_op(FN_DIVU, 32'hDEAD_BEEF, 32'h0000_1234,
            ref_result(FN_DIVU, 32'hDEAD_BEEF, 32'h0000_1234), 4);
    send_op(FN_DIV, 32'h8765_4321, 32'h0000_0077,
            ref_result(FN_DIV, 32'h8765_4321, 32'h0000_0077), 9);
    send_op(FN_MULU, 32'h0BAD_F00D, 32'h0000_0003,
            ref_result(FN_MULU, 32'h0BAD_F00D, 32'h0000_0003), 17);
    // next request goes straight through
    send_op(FN_MUL, 32'h0000_0007, 32'h0000_0006, 64'd42, 0);
  endtask

  task automatic test_random(input int count);
    muldiv_fn_t fn;
    word_t      a;
    word_t      b;
    for (int i = 0; i < count; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      if (i % 2 == 0) begin
        fn = (rand_bits(1) != 0) ? FN_MULU : FN_MUL;
      end else begin
        fn = (rand_bits(1) != 0) ? FN_DIVU : FN_DIV;
        // shrink divisor now and then for larger quotients
        b  = b >> rand_bits(5);
      end
      send_op(fn, a, b, ref_result(fn, a, b), 0);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_fn    = FN_MUL;
    req_a     = '0;
    req_b     = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    lfsr_q    = 32'h4860_DDEA;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_known_values();
    test_corners(FN_MUL);
    test_corners(FN_MULU);
    test_corners(FN_DIV);
    test_corners(FN_DIVU);
    test_backpressure();
    test_random(200);
    $display("Regression passed");
    $finish;
  end

endmodule

/* int_muldiv_unit.sv */
/* top of the iterative multiply/divide unit, one request in flight
   routes by function code to the multiplier or divider and returns its result */

module int_muldiv_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  imuldiv_pkg::muldiv_fn_t req_fn,
  input  imuldiv_pkg::word_t      req_a,
  input  imuldiv_pkg::word_t      req_b,
  input  logic                    req_val,
  output logic                    req_rdy,
  output imuldiv_pkg::dword_t     resp_result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);
  import imuldiv_pkg::*;

  logic   busy_q;
  logic   req_go;
  logic   is_mul;
  logic   req_signed;

  // multiplier side
  logic   mul_req_val;
  logic   mul_resp_val;
  logic   mul_resp_rdy;
  logic   mul_load;
  logic   mul_step;
  logic   mul_last;
  dword_t mul_result;

  // divider side
  logic   div_req_val;
  logic   div_resp_val;
  logic   div_resp_rdy;
  logic   div_load;
  logic   div_step;
  logic   div_last;
  dword_t div_result;

  // ---------------------------------------------------------------------------
  // request steering
  // ---------------------------------------------------------------------------

  assign req_rdy    = ~busy_q;
  assign req_go     = req_val & req_rdy;
  assign is_mul     = (req_fn == FN_MUL) || (req_fn == FN_MULU);
  assign req_signed = (req_fn == FN_MUL) || (req_fn == FN_DIV);

  // idle top means both units sit in IDLE, so their own rdy is not checked
  assign mul_req_val = req_go & is_mul;
  assign div_req_val = req_go & ~is_mul;

  // busy from accept until the response leaves
  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
    end else if (req_go) begin
      busy_q <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      busy_q <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------------
  // response mux
  // ---------------------------------------------------------------------------

  // at most one unit is ever in DONE
  assign resp_val     = mul_resp_val | div_resp_val;
  assign mul_resp_rdy = resp_rdy & mul_resp_val;
  assign div_resp_rdy = resp_rdy & div_resp_val;
  assign resp_result  = mul_resp_val ? mul_result : div_result;

  // ---------------------------------------------------------------------------
  // units
  // ---------------------------------------------------------------------------

  int_mul_ctrl u_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .load     (mul_load),
    .step     (mul_step),
    .is_last  (mul_last)
  );

  int_mul_dpath u_mul_dpath (
    .clk        (clk),
    .reset      (reset),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_signed (req_signed),
    .load       (mul_load),
    .step       (mul_step),
    .is_last    (mul_last),
    .result     (mul_result)
  );

  int_div_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .load     (div_load),
    .step     (div_step),
    .is_last  (div_last)
  );

  int_div_dpath u_div_dpath (
    .clk        (clk),
    .reset      (reset),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_signed (req_signed),
    .load       (div_load),
    .step       (div_step),
    .is_last    (div_last),
    .result     (div_result)
  );

endmodule

/* int_div_ctrl.sv */
/* sequencer for the restoring divider
   same handshake and enables as the multiplier sequencer */

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step,
  input  logic is_last
);
  import imuldiv_pkg::*;

  div_state_t state_q;
  div_state_t state_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= DIV_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ---------------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      DIV_IDLE: begin
        if (load) begin
          state_d = DIV_CALC;
        end
      end
      DIV_CALC: begin
        // leave after the step taken at count zero
        if (step && is_last) begin
          state_d = DIV_DONE;
        end
      end
      DIV_DONE: begin
        if (resp_val && resp_rdy) begin
          state_d = DIV_IDLE;
        end
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  // datapath enables and handshake
  assign req_rdy  = (state_q == DIV_IDLE);
  assign resp_val = (state_q == DIV_DONE);
  assign load     = req_val & req_rdy;
  assign step     = (state_q == DIV_CALC);

endmodule

/* int_div_dpath.sv */
/* restoring divider datapath, driven by int_div_ctrl
   result packs remainder in the upper half and quotient in the lower half */

`include "imuldiv_defs.svh"

module int_div_dpath (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  req_a,
  input  imuldiv_pkg::word_t  req_b,
  input  logic                req_signed,
  input  logic                load,
  input  logic                step,
  output logic                is_last,
  output imuldiv_pkg::dword_t result
);
  import imuldiv_pkg::*;

  logic   a_neg;
  logic   b_neg;
  word_t  a_mag;
  word_t  b_mag;

  // remainder in upper half, dividend bits turning into quotient in lower half
  dword_t rq_q;
  dword_t rq_shift;
  dword_t rq_next;
  word_t  dvsr_q;
  count_t cnt_q;
  logic   q_neg_q;
  logic   r_neg_q;

  // one extra bit catches both the bit shifted out and the borrow
  logic [`IMULDIV_XLEN:0] trial;
  logic   borrow;

  word_t  rem_mag;
  word_t  quo_mag;
  word_t  rem_fix;
  word_t  quo_fix;

  // ---------------------------------------------------------------------------
  // operand conditioning
  // ---------------------------------------------------------------------------

  assign a_neg = req_signed & req_a[`IMULDIV_XLEN-1];
  assign b_neg = req_signed & req_b[`IMULDIV_XLEN-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // ---------------------------------------------------------------------------
  // trial subtract
  // ---------------------------------------------------------------------------

  assign rq_shift = {rq_q[2*`IMULDIV_XLEN-2:0], 1'b0};

  // partial remainder can reach 33 bits after the shift, so keep the top bit
  assign trial = {rq_q[2*`IMULDIV_XLEN-1], rq_shift[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN]}
               - {1'b0, dvsr_q};
  assign borrow = trial[`IMULDIV_XLEN];

  // restore on borrow, otherwise keep the difference and set the quotient bit
  assign rq_next = borrow ? rq_shift
                          : {trial[`IMULDIV_XLEN-1:0], rq_shift[`IMULDIV_XLEN-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= count_t'(`IMULDIV_STEPS - 1);
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rq_q    <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      dvsr_q  <= b_mag;
      q_neg_q <= a_neg ^ b_neg;
      // remainder follows the dividend
      r_neg_q <= a_neg;
    end else if (step) begin
      rq_q <= rq_next;
    end
  end

  assign is_last = (cnt_q == '0);

  // ---------------------------------------------------------------------------
  // sign correction
  // ---------------------------------------------------------------------------

  // zero divisor never borrows: all-ones quotient, dividend left as remainder
  assign rem_mag = rq_q[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];
  assign quo_mag = rq_q[`IMULDIV_XLEN-1:0];
  assign rem_fix = r_neg_q ? (~rem_mag + 1'b1) : rem_mag;
  assign quo_fix = q_neg_q ? (~quo_mag + 1'b1) : quo_mag;

  assign result = {rem_fix, quo_fix};

endmodule

/* int_mul_ctrl.sv */
/* sequencer for the shift-and-add multiplier
   val/rdy on both sides, load and step go to int_mul_dpath */

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step,
  input  logic is_last
);
  import imuldiv_pkg::*;

  mul_state_t state_q;
  mul_state_t state_d;

  // ---------------------------------------------------------------------------
  // state register
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ---------------------------------------------------------------------------
  // next state
  // ---------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      MUL_IDLE: begin
        // operands captured on the accepting edge
        if (load) begin
          state_d = MUL_CALC;
        end
      end
      MUL_CALC: begin
        if (step && is_last) begin
          state_d = MUL_DONE;
        end
      end
      MUL_DONE: begin
        // wait here as long as the consumer stalls
        if (resp_val && resp_rdy) begin
          state_d = MUL_IDLE;
        end
      end
      default: begin
        state_d = MUL_IDLE;
      end
    endcase
  end

  // ---------------------------------------------------------------------------
  // outputs
  // ---------------------------------------------------------------------------

  assign req_rdy  = (state_q == MUL_IDLE);
  assign resp_val = (state_q == MUL_DONE);
  assign load     = req_val & req_rdy;
  // one iteration every CALC cycle
  assign step     = (state_q == MUL_CALC);

endmodule

/* int_mul_dpath.sv */
/* shift-and-add multiplier datapath, driven by int_mul_ctrl
   works on magnitudes and fixes the product sign at the output */

`include "imuldiv_defs.svh"

module int_mul_dpath (
  input  logic                clk,
  input  logic                reset,
  input  imuldiv_pkg::word_t  req_a,
  input  imuldiv_pkg::word_t  req_b,
  input  logic                req_signed,
  input  logic                load,
  input  logic                step,
  output logic                is_last,
  output imuldiv_pkg::dword_t result
);
  import imuldiv_pkg::*;

  // operand signs, only meaningful for signed requests
  logic   a_neg;
  logic   b_neg;
  word_t  a_mag;
  word_t  b_mag;

  // iteration state
  dword_t a_q;
  word_t  b_q;
  dword_t acc_q;
  dword_t acc_next;
  count_t cnt_q;
  logic   neg_q;

  // ---------------------------------------------------------------------------
  // operand conditioning
  // ---------------------------------------------------------------------------

  assign a_neg = req_signed & req_a[`IMULDIV_XLEN-1];
  assign b_neg = req_signed & req_b[`IMULDIV_XLEN-1];

  // two's complement negate when the operand is negative
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // ---------------------------------------------------------------------------
  // iteration
  // ---------------------------------------------------------------------------

  // add the shifted multiplicand only when the current multiplier bit is set
  assign acc_next = b_q[0] ? (acc_q + a_q) : acc_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= count_t'(`IMULDIV_STEPS - 1);
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // multiplicand sits zero-extended in the low half
      a_q   <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      b_q   <= b_mag;
      acc_q <= '0;
      neg_q <= a_neg ^ b_neg;
    end else if (step) begin
      acc_q <= acc_next;
      a_q   <= a_q << 1;
      b_q   <= b_q >> 1;
    end
  end

  // last iteration is the one taken with the counter at zero
  assign is_last = (cnt_q == '0);

  // accumulator stops moving once step drops, so this holds through DONE
  assign result = neg_q ? (~acc_q + 1'b1) : acc_q;

endmodule

/* imuldiv_pkg.sv */
/* shared types for the iterative multiply/divide unit
   widths come from the defs header, import where a type is needed */

`include "imuldiv_defs.svh"

package imuldiv_pkg;

  // ---------------------------------------------------------------------------
  // data vectors
  // ---------------------------------------------------------------------------

  // one operand
  typedef logic [`IMULDIV_XLEN-1:0] word_t;
  // full product, or remainder in upper half and quotient in lower half
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;
  // iteration counter
  typedef logic [`IMULDIV_CNT_W-1:0] count_t;

  // ---------------------------------------------------------------------------
  // function code and controller states
  // ---------------------------------------------------------------------------

  // signed / unsigned multiply, signed / unsigned divide
  typedef enum logic [1:0] {FN_MUL, FN_MULU, FN_DIV, FN_DIVU} muldiv_fn_t;

  // multiplier sequencer
  typedef enum logic [1:0] {MUL_IDLE, MUL_CALC, MUL_DONE} mul_state_t;

  // divider sequencer
  typedef enum logic [1:0] {DIV_IDLE, DIV_CALC, DIV_DONE} div_state_t;

endpackage

/* imuldiv_defs.svh */
/* width and iteration macros for the iterative multiply/divide unit
   pulled in by the package, both datapaths and the testbench */

`ifndef IMULDIV_DEFS_SVH
`define IMULDIV_DEFS_SVH

// ---------------------------------------------------------------------------
// operand and result sizing
// ---------------------------------------------------------------------------

// width of one operand, results are twice this
`define IMULDIV_XLEN 32

// ---------------------------------------------------------------------------
// iteration control
// ---------------------------------------------------------------------------

// one iteration per operand bit, for mul and div alike
`define IMULDIV_STEPS 32

// counter runs from steps-1 down to zero
`define IMULDIV_CNT_W 5

`endif
